/* bench/cpu16_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu16_chk (
    input logic            clk,
    input logic            reset,
    input logic            hold,
    input logic            busy,
    input logic            write,
    input cpu_pkg::state_t state
);
    import cpu_pkg::*;

    int failures = 0;    // failed assertion count

    // a held select keeps the core busy
    a_hold_busy: assert property (@(posedge clk) disable iff (reset)
        (state == ST_SELECT && hold) |=> busy)
        else begin
            $error("busy went low after a held select cycle");
            failures++;
        end

    a_write_pulse: assert property (@(posedge clk) disable iff (reset)
        write |=> !write)
        else begin
            $error("write stayed high for two cycles");
            failures++;
        end

    // first cycle out of reset
    a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> (busy && !write))
        else begin
            $error("busy low or write high right after reset");
            failures++;
        end

endmodule

bind cpu16_top cpu16_chk u_chk (
    .clk   (clk),
    .reset (reset),
    .hold  (hold),
    .busy  (busy),
    .write (write),
    .state (u_control.state)
);

`default_nettype wire

/* bench/cpu16_vectors.mem */
// program: word count, then the words loaded at the reset vector f000
// writes: count, then one expected address and data pair per line
001F
D8FF D901 DA00   // r0 = 00ff, r1 = 0001, r2 = 0000
0269             // sub r2, r1 gives ffff and a borrow
0261             // add r2, r1 gives 0000 with carry set
0071             // adc r0, r1 gives 0101
3010 3211        // store r0 at 0010, r2 at 0011
E902             // r1 = 0001 - 02, borrow again
F803             // sbb r0, 03 gives 00fd
0120 0030        // asl r1, then rol r0 pulls in the carry
D0F0             // xor r0, f0 gives 010b
3012 3113        // store r0 at 0012, r1 at 0013
8A01 3214        // branch on zero set, not taken
8201 3015        // branch on zero clear, skips the store
DE40             // sp = 0040
5006 5106        // push r0 then r1
4B0E 4C0E        // pop into r3 and r4, offset +1
DD20             // r5 = 0020
53F5 541D        // r3 at r5-2, r4 at r5+3
5206             // push r2 shows sp back at 0040
2D10             // load r5 from 0010
6005 1234        // direct store of r5 at 1234
000B
0010 0101
0011 0000
0012 010B
0013 FFFE
0014 0000
0040 010B
003F FFFE
001E FFFE
0023 010B
0040 0000
1234 0101

/* bench/tb_cpu16.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu16;
    import cpu_pkg::*;

    localparam word_t PROG_BASE = 16'hf000;    // DUT default reset vector
    localparam int    VEC_WORDS = 256;

    logic  clk;
    logic  reset;
    logic  hold;
    logic  busy;
    word_t address;
    word_t data_in;
    word_t data_out;
    logic  write;

    word_t mem [0:65535];
    word_t vec [0:VEC_WORDS-1];

    word_t bus_addr;     // bus as seen just before the rising edge
    word_t bus_wdata;
    logic  bus_wr;
    word_t rd_word;

    int    prog_len;
    int    wr_total;
    int    wr_seen;
    int    limit;
    int    cycles;
    logic  done;

    cpu16_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .busy     (busy),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .write    (write)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string test_name, input word_t expected, input word_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("mismatch %s address: expected %h, actual %h",
                                        test_name, expected, actual));
    endtask

    task automatic check_data(input string test_name, input word_t expected, input word_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("mismatch %s data: expected %h, actual %h",
                                        test_name, expected, actual));
    endtask

    always @(negedge clk) begin
        bus_addr  = address;
        bus_wdata = data_out;
        bus_wr    = write;
        if (u_dut.u_chk.failures != 0)
            stop_with_failure("an assertion in cpu16_chk failed");
    end

    // synchronous memory with one cycle of read latency
    always @(posedge clk) begin
        if (bus_wr === 1'b1 && !done) begin
            check_addr($sformatf("write %0d", wr_seen),
                       vec[prog_len + 2 + 2 * wr_seen], bus_addr);
            check_data($sformatf("write %0d", wr_seen),
                       vec[prog_len + 3 + 2 * wr_seen], bus_wdata);
            mem[bus_addr] = bus_wdata;
            wr_seen++;
            if (wr_seen == wr_total)
                done = 1'b1;
        end
        rd_word = mem[bus_addr];
        #1;
        data_in = rd_word;
    end

    // random hold stretches between gaps of a few cycles
    initial begin
        int gap;
        int stretch;
        void'($urandom(32'hec62_3ea3));
        @(negedge reset);
        forever begin
            gap     = 4 + ($urandom % 8);
            stretch = 1 + ($urandom % 3);
            repeat (gap) @(posedge clk);
            #1 hold = 1'b1;
            repeat (stretch) @(posedge clk);
            #1 hold = 1'b0;
        end
    end

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        hold    = 1'b0;
        data_in = '0;
        done    = 1'b0;
        wr_seen = 0;
        cycles  = 0;
        for (int i = 0; i < VEC_WORDS; i++)
            vec[i] = 'x;
        for (int i = 0; i < 65536; i++)
            mem[i] = '0;
        $readmemh("bench/cpu16_vectors.mem", vec);
        if ($isunknown(vec[0]))
            stop_with_failure("vector file bench/cpu16_vectors.mem could not be read");
        prog_len = vec[0];
        wr_total = vec[prog_len + 1];
        for (int i = 0; i < prog_len; i++)
            mem[PROG_BASE + i] = vec[i + 1];
        limit = 10 + 12 * prog_len;

        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (done && u_dut.u_chk.failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else if (done) begin
            stop_with_failure("an assertion in cpu16_chk failed");
        end else begin
            stop_with_failure($sformatf("program did not finish within %0d cycles", limit));
        end
    end

endmodule

`default_nettype wire

/* common/alu_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface alu_port_if;
    import isa_pkg::*;
    import cpu_pkg::*;

    alu_op_t     op;
    word_t       a;
    word_t       b;
    logic        compute;   // flags load on this strobe

    logic [16:0] result;    // bit 16 is carry out
    logic        carry;
    logic        zero;
    logic        neg;

    modport ctl (
        output op, a, b, compute,
        input  result, carry, zero, neg
    );

    modport alu (
        input  op, a, b, compute,
        output result, carry, zero, neg
    );

endinterface

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_SELECT,
        ST_DECODE_WAIT,
        ST_DECODE,
        ST_COMPUTE_WAIT,
        ST_COMPUTE,
        ST_STORE_ADDR_WAIT,
        ST_STORE_ADDR
    } state_t;

    // dedicated registers
    localparam reg_idx_t REG_SP = 3'd6;
    localparam reg_idx_t REG_IP = 3'd7;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // bit 2 of the code marks the ops that write carry
    typedef enum logic [3:0] {
        ALU_ZERO   = 4'h0,
        ALU_LOAD_A = 4'h1,
        ALU_INC    = 4'h2,
        ALU_DEC    = 4'h3,
        ALU_ASL    = 4'h4,
        ALU_LSR    = 4'h5,
        ALU_ROL    = 4'h6,
        ALU_ROR    = 4'h7,
        ALU_OR     = 4'h8,
        ALU_AND    = 4'h9,
        ALU_XOR    = 4'ha,
        ALU_LOAD_B = 4'hb,
        ALU_ADD    = 4'hc,
        ALU_SUB    = 4'hd,
        ALU_ADC    = 4'he,
        ALU_SBB    = 4'hf
    } alu_op_t;

    typedef logic [3:0]        cond_t;   // sense, neg, zero, carry
    typedef logic [7:0]        imm8_t;
    typedef logic signed [4:0] ofs5_t;

    localparam int COND_CARRY = 0;
    localparam int COND_ZERO  = 1;
    localparam int COND_NEG   = 2;
    localparam int COND_SENSE = 3;     // flag must equal this bit

    // opcode patterns with ? on the operand fields
    localparam logic [15:0] PAT_ALU_RR    = 16'b00000???0???????;
    localparam logic [15:0] PAT_ZP_LOAD   = 16'b00101???????????;
    localparam logic [15:0] PAT_ZP_STORE  = 16'b00110???????????;
    localparam logic [15:0] PAT_IDX_LOAD  = 16'b01001???????????;
    localparam logic [15:0] PAT_IDX_STORE = 16'b01010???????????;
    localparam logic [15:0] PAT_DIR_STORE = 16'b0110000000000???;
    localparam logic [15:0] PAT_BRANCH    = 16'b1000????????????;
    localparam logic [15:0] PAT_ALU_IMM   = 16'b11??????????????;

    function automatic alu_op_t rr_op(input logic [15:0] instr);
        return alu_op_t'(instr[6:3]);
    endfunction

    // immediate form only reaches the binary half of the table
    function automatic alu_op_t imm_op(input logic [15:0] instr);
        return alu_op_t'(instr[14:11]);
    endfunction

    function automatic cond_t cond_of(input logic [15:0] instr);
        return instr[11:8];
    endfunction

    function automatic imm8_t imm8_of(input logic [15:0] instr);
        return instr[7:0];
    endfunction

    function automatic ofs5_t ofs5_of(input logic [15:0] instr);
        return instr[7:3];
    endfunction

endpackage

`default_nettype wire

/* common/reg_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface reg_port_if;
    import cpu_pkg::*;

    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    word_t    ra_data;
    word_t    rb_data;

    logic     wr_en;       // main write wins over sp/ip
    reg_idx_t wr_idx;
    word_t    wr_data;

    logic     sp_adj;
    logic     sp_dec;      // 1 = decrement, 0 = increment

    logic     ip_we;
    word_t    ip_data;

    word_t    sp;
    word_t    ip;

    modport ctl (
        output ra_idx, rb_idx, wr_en, wr_idx, wr_data, sp_adj, sp_dec, ip_we, ip_data,
        input  ra_data, rb_data, sp, ip
    );

    modport rf (
        input  ra_idx, rb_idx, wr_en, wr_idx, wr_data, sp_adj, sp_dec, ip_we, ip_data,
        output ra_data, rb_data, sp, ip
    );

endinterface

`default_nettype wire

/* control/cpu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_control #(
    parameter cpu_pkg::word_t RESET_VECTOR = 16'hf000,
    parameter bit             RAM_WAIT     = 1'b1
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           hold,
    output logic           busy,
    output cpu_pkg::word_t address,
    input  cpu_pkg::word_t data_in,
    output cpu_pkg::word_t data_out,
    output logic           write,
    reg_port_if.ctl        regs,
    alu_port_if.ctl        alu_p
);
    import isa_pkg::*;
    import cpu_pkg::*;

    state_t   state;
    state_t   state_next;
    word_t    opcode;          // instruction latched at decode
    alu_op_t  alu_op;
    alu_op_t  dec_op;

    logic     wb_we;           // registered result write
    reg_idx_t wb_idx;
    word_t    wb_data;

    reg_idx_t dec_a;
    reg_idx_t dec_b;
    reg_idx_t op_a;
    reg_idx_t op_b;

    logic     is_alu_rr;
    logic     is_alu_imm;
    logic     is_zp_load;
    logic     is_zp_store;
    logic     is_idx_load;
    logic     is_idx_store;
    logic     is_dir_store;
    logic     is_branch;
    logic     is_bad;
    logic     dec_is_load;

    cond_t    cond;
    imm8_t    disp;
    ofs5_t    ofs;
    logic     branch_taken;
    word_t    index_base;
    word_t    index_addr;
    word_t    branch_target;

    assign dec_a = data_in[10:8];
    assign dec_b = data_in[2:0];
    assign op_a  = opcode[10:8];   // destination of alu ops
    assign op_b  = opcode[2:0];

    always_comb begin
        is_alu_rr    = 1'b0;
        is_alu_imm   = 1'b0;
        is_zp_load   = 1'b0;
        is_zp_store  = 1'b0;
        is_idx_load  = 1'b0;
        is_idx_store = 1'b0;
        is_dir_store = 1'b0;
        is_branch    = 1'b0;
        is_bad       = 1'b0;
        casez (data_in)
            PAT_ALU_RR:    is_alu_rr    = 1'b1;
            PAT_ALU_IMM:   is_alu_imm   = 1'b1;
            PAT_ZP_LOAD:   is_zp_load   = 1'b1;
            PAT_ZP_STORE:  is_zp_store  = 1'b1;
            PAT_IDX_LOAD:  is_idx_load  = 1'b1;
            PAT_IDX_STORE: is_idx_store = 1'b1;
            PAT_DIR_STORE: is_dir_store = 1'b1;
            PAT_BRANCH:    is_branch    = 1'b1;
            default:       is_bad       = 1'b1;   // re-vector through reset
        endcase
    end

    assign dec_is_load = is_zp_load | is_idx_load;
    assign dec_op = is_alu_imm ? imm_op(data_in) : is_alu_rr ? rr_op(data_in) : ALU_LOAD_B;

    // address generation
    assign ofs           = ofs5_of(data_in);
    assign index_base    = (dec_b == REG_SP) ? regs.sp : regs.rb_data;
    assign index_addr    = index_base + {{11{ofs[4]}}, ofs};
    assign disp          = imm8_of(data_in);
    assign branch_target = regs.ip + {{8{disp[7]}}, disp};   // ip already past the branch

    // empty condition mask means branch always
    assign cond = cond_of(data_in);
    assign branch_taken = (cond[COND_NEG:COND_CARRY] == 3'b000) ||
                          (cond[COND_CARRY] && (cond[COND_SENSE] == alu_p.carry)) ||
                          (cond[COND_ZERO]  && (cond[COND_SENSE] == alu_p.zero)) ||
                          (cond[COND_NEG]   && (cond[COND_SENSE] == alu_p.neg));

    // decode reads from the bus, later states from the latched word
    assign regs.ra_idx = (state == ST_DECODE) ? dec_a : op_a;
    assign regs.rb_idx = (state == ST_DECODE) ? dec_b : op_b;

    assign regs.wr_en   = wb_we;
    assign regs.wr_idx  = wb_idx;
    assign regs.wr_data = wb_data;

    assign regs.sp_adj = (state == ST_DECODE) && (dec_b == REG_SP) &&
                         (is_idx_load || is_idx_store);
    assign regs.sp_dec = is_idx_store;      // push on store, pop on load

    always_comb begin
        regs.ip_we   = 1'b0;
        regs.ip_data = regs.ip + 16'd1;
        case (state)
            ST_RESET: begin
                regs.ip_we   = 1'b1;
                regs.ip_data = RESET_VECTOR;
            end
            ST_SELECT: regs.ip_we = !hold;
            ST_DECODE: begin
                if (is_dir_store) begin
                    regs.ip_we = 1'b1;                  // step over the address word
                end else if (is_branch && branch_taken) begin
                    regs.ip_we   = 1'b1;
                    regs.ip_data = branch_target;
                end
            end
            default: ;
        endcase
    end

    // operand b is the constant, memory data or a register
    assign alu_p.op      = alu_op;
    assign alu_p.a       = regs.ra_data;
    assign alu_p.b       = opcode[15] ? {8'h00, opcode[7:0]} :
                           opcode[11] ? data_in : regs.rb_data;
    assign alu_p.compute = (state == ST_COMPUTE);

    always_comb begin
        state_next = state;
        case (state)
            ST_RESET:       state_next = ST_SELECT;
            ST_SELECT:      if (!hold) state_next = RAM_WAIT ? ST_DECODE_WAIT : ST_DECODE;
            ST_DECODE_WAIT: state_next = ST_DECODE;
            ST_DECODE: begin
                if (is_bad)
                    state_next = ST_RESET;
                else if (is_zp_store || is_idx_store || is_branch)
                    state_next = ST_SELECT;
                else if (is_dir_store)
                    state_next = RAM_WAIT ? ST_STORE_ADDR_WAIT : ST_STORE_ADDR;
                else if (dec_is_load && RAM_WAIT)
                    state_next = ST_COMPUTE_WAIT;
                else
                    state_next = ST_COMPUTE;
            end
            ST_COMPUTE_WAIT:    state_next = ST_COMPUTE;
            ST_COMPUTE:         state_next = ST_SELECT;
            ST_STORE_ADDR_WAIT: state_next = ST_STORE_ADDR;
            ST_STORE_ADDR:      state_next = ST_SELECT;
            default:            state_next = ST_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            busy  <= 1'b1;
            write <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ST_SELECT) busy <= hold;   // low once a fetch goes out
            write <= ((state == ST_DECODE) && (is_zp_store || is_idx_store)) ||
                     (state == ST_STORE_ADDR);
            wb_we <= (state == ST_COMPUTE);
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_SELECT: if (!hold) address <= regs.ip;
            ST_DECODE: begin
                opcode <= data_in;
                alu_op <= dec_op;
                if (is_zp_load || is_zp_store)
                    address <= {8'h00, disp};
                else if (is_idx_load || is_idx_store)
                    address <= index_addr;
                else if (is_dir_store)
                    address <= regs.ip;                 // fetch second word
                if (is_zp_store || is_idx_store || is_dir_store)
                    data_out <= is_dir_store ? regs.rb_data : regs.ra_data;
            end
            ST_STORE_ADDR: address <= data_in;
            ST_COMPUTE: begin
                wb_idx  <= op_a;
                wb_data <= alu_p.result[15:0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* files.f */
common/isa_pkg.sv
common/cpu_pkg.sv
common/reg_port_if.sv
common/alu_port_if.sv
src/reg_file.sv
src/alu.sv
control/cpu_control.sv
src/cpu16_top.sv
bench/cpu16_chk.sv
bench/tb_cpu16.sv

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input logic clk,
    input logic reset,
    alu_port_if.alu port
);
    import isa_pkg::*;
    import cpu_pkg::*;

    logic [16:0] y;
    logic [16:0] ext_a;
    logic [16:0] ext_b;
    logic [16:0] cin;
    logic        c_flag;
    logic        z_flag;
    logic        n_flag;

    assign ext_a = {1'b0, port.a};
    assign ext_b = {1'b0, port.b};
    assign cin   = {16'h0000, c_flag};

    always_comb begin
        case (port.op)
            ALU_ZERO:   y = '0;
            ALU_LOAD_A: y = ext_a;
            ALU_INC:    y = ext_a + 17'd1;
            ALU_DEC:    y = ext_a - 17'd1;
            ALU_ASL:    y = {port.a, 1'b0};
            ALU_LSR:    y = {port.a[0], 1'b0, port.a[15:1]};    // shifted-out bit to carry
            ALU_ROL:    y = {port.a, c_flag};
            ALU_ROR:    y = {port.a[0], c_flag, port.a[15:1]};
            ALU_OR:     y = ext_a | ext_b;
            ALU_AND:    y = ext_a & ext_b;
            ALU_XOR:    y = ext_a ^ ext_b;
            ALU_LOAD_B: y = ext_b;
            ALU_ADD:    y = ext_a + ext_b;
            ALU_SUB:    y = ext_a - ext_b;                       // bit 16 is borrow
            ALU_ADC:    y = ext_a + ext_b + cin;
            ALU_SBB:    y = ext_a - ext_b - cin;
            default:    y = '0;
        endcase
    end

    assign port.result = y;
    assign port.carry  = c_flag;
    assign port.zero   = z_flag;
    assign port.neg    = n_flag;

    always_ff @(posedge clk) begin
        if (reset) begin
            c_flag <= 1'b0;
            z_flag <= 1'b0;
            n_flag <= 1'b0;
        end else if (port.compute) begin
            if (port.op[2]) c_flag <= y[16];     // shift and arithmetic ops only
            z_flag <= (y[15:0] == 16'h0000);
            n_flag <= y[15];
        end
    end

endmodule

`default_nettype wire

/* src/cpu16_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu16_top #(
    parameter cpu_pkg::word_t RESET_VECTOR = 16'hf000,
    parameter bit             RAM_WAIT     = 1'b1
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           hold,
    output logic           busy,
    output cpu_pkg::word_t address,
    input  cpu_pkg::word_t data_in,
    output cpu_pkg::word_t data_out,
    output logic           write
);

    reg_port_if regs_if ();
    alu_port_if alu_if ();

    cpu_control #(
        .RESET_VECTOR (RESET_VECTOR),
        .RAM_WAIT     (RAM_WAIT)
    ) u_control (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .busy     (busy),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .write    (write),
        .regs     (regs_if.ctl),
        .alu_p    (alu_if.ctl)
    );

    reg_file #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_regs (
        .clk   (clk),
        .reset (reset),
        .port  (regs_if.rf)
    );

    alu u_alu (
        .clk   (clk),
        .reset (reset),
        .port  (alu_if.alu)
    );

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter cpu_pkg::word_t RESET_VECTOR = 16'hf000
) (
    input logic clk,
    input logic reset,
    reg_port_if.rf port
);
    import cpu_pkg::*;

    word_t mem [8];

    // asynchronous reads
    assign port.ra_data = mem[port.ra_idx];
    assign port.rb_data = mem[port.rb_idx];
    assign port.sp      = mem[REG_SP];
    assign port.ip      = mem[REG_IP];

    always_ff @(posedge clk) begin
        if (reset) begin
            mem[REG_IP] <= RESET_VECTOR;
        end else begin
            if (port.sp_adj) begin
                mem[REG_SP] <= port.sp_dec ? mem[REG_SP] - 16'd1 : mem[REG_SP] + 16'd1;
            end
            if (port.ip_we) begin
                mem[REG_IP] <= port.ip_data;
            end
            // main write comes last so it overrides sp/ip updates
            if (port.wr_en) begin
                mem[port.wr_idx] <= port.wr_data;
            end
        end
    end

endmodule

`default_nettype wire
